// ==== source/prbs_chk_defs.svh ====
`ifndef PRBS_CHK_DEFS_SVH
`define PRBS_CHK_DEFS_SVH

// data path
`define PRBS_DATA_W 64
`define PRBS_BYTE_W 3

// lock and tolerance counters
`define PRBS_CNT_W 4
`define PRBS_ERR_W 32

// axi4-lite register map
`define PRBS_AXI_AW 4
`define PRBS_REG_CTRL 4'h0
`define PRBS_REG_CLEAR 4'h4
`define PRBS_REG_STATUS 4'h8
`define PRBS_REG_ERR 4'hC

`endif

// ==== source/prbs_chk_data_pkg.sv ====
`include "prbs_chk_defs.svh"

package prbs_chk_data_pkg;

   typedef logic [`PRBS_DATA_W-1:0] prbs_word_t;
   typedef logic [`PRBS_BYTE_W-1:0] byte_idx_t;  // highest valid byte

   // codes outside the list behave as prbs7
   typedef enum logic [2:0] {
      PRBS7  = 3'd0,  // x^7 + x^6 + 1
      PRBS15 = 3'd1,  // x^15 + x^14 + 1
      PRBS31 = 3'd2   // x^31 + x^28 + 1
   } prbs_mode_e;

endpackage

// ==== source/prbs_chk_cfg_pkg.sv ====
`include "prbs_chk_defs.svh"

package prbs_chk_cfg_pkg;
   import prbs_chk_data_pkg::*;

   // control register at offset 0x0
   typedef struct packed {
      logic [`PRBS_CNT_W-1:0] match_cnt;      // matches before lock, minus one
      logic [`PRBS_CNT_W-1:0] tolerance;      // beats before checking is forced
      logic                   rsvd;
      logic                   lock_continue;  // count consecutive matches only
      logic                   load;           // reseed from input on every beat
      logic                   order;          // incoming word is inverted
      prbs_mode_e             mode;
      logic                   chk_en;
   } prbs_ctrl_t;

   typedef struct packed {
      logic                   check;
      logic                   fail;
      logic [`PRBS_ERR_W-1:0] err_count;
   } prbs_status_t;

endpackage

// ==== source/prbs_chk_cfg_if.sv ====
interface prbs_chk_cfg_if import prbs_chk_cfg_pkg::*; ();

   prbs_ctrl_t   ctrl;
   logic         err_clear;  // single cycle strobe
   prbs_status_t status;

   // register block side
   modport regs (
      output ctrl,
      output err_clear,
      input  status
   );

   modport chk (
      input  ctrl,
      input  err_clear,
      output status
   );

endinterface

// ==== source/prbs_chk_regs.sv ====
`include "prbs_chk_defs.svh"

module prbs_chk_regs import prbs_chk_cfg_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PRBS_AXI_AW-1:0] awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [31:0]             wdata,
   input  logic [3:0]              wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [`PRBS_AXI_AW-1:0] araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [31:0]             rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   prbs_chk_cfg_if.regs            cfg
);

   prbs_ctrl_t              ctrl_q;
   logic                    clear_q;
   logic                    aw_full;
   logic                    w_full;
   logic [`PRBS_AXI_AW-1:0] aw_addr_q;
   logic [31:0]             w_data_q;
   logic [3:0]              w_strb_q;
   logic                    aw_hs;
   logic                    w_hs;
   logic                    wr_fire;
   logic [`PRBS_AXI_AW-1:0] wr_addr;
   logic [31:0]             wr_data;
   logic [3:0]              wr_strb;
   logic [15:0]             ctrl_wr;
   logic [31:0]             rd_word;

   // no new write accepted while a response is pending
   assign awready = ~aw_full & ~bvalid;
   assign wready  = ~w_full & ~bvalid;
   assign arready = ~rvalid;
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   assign aw_hs   = awvalid & awready;
   assign w_hs    = wvalid & wready;
   assign wr_fire = (aw_full | aw_hs) & (w_full | w_hs);
   assign wr_addr = aw_full ? aw_addr_q : awaddr;  // bypass when taken this cycle
   assign wr_data = w_full ? w_data_q : wdata;
   assign wr_strb = w_full ? w_strb_q : wstrb;

   always_comb begin
      ctrl_wr = ctrl_q;
      if (wr_strb[0]) begin
         ctrl_wr[7:0] = wr_data[7:0];
      end
      if (wr_strb[1]) begin
         ctrl_wr[15:8] = wr_data[15:8];
      end
      ctrl_wr[7] = 1'b0;  // reserved
   end

   always_comb begin
      case (araddr)
         `PRBS_REG_CTRL:   rd_word = {16'h0000, ctrl_q};
         `PRBS_REG_STATUS: rd_word = {30'd0, cfg.status.fail, cfg.status.check};
         `PRBS_REG_ERR:    rd_word = cfg.status.err_count;
         default:          rd_word = 32'd0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
         bvalid  <= 1'b0;
         ctrl_q  <= '0;
         clear_q <= 1'b0;
      end else begin
         clear_q <= 1'b0;
         if (wr_fire) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b1;
            if (wr_addr == `PRBS_REG_CTRL) begin
               ctrl_q <= prbs_ctrl_t'(ctrl_wr);
            end
            clear_q <= (wr_addr == `PRBS_REG_CLEAR) & wr_data[0];
         end else begin
            if (aw_hs) aw_full <= 1'b1;
            if (w_hs) w_full <= 1'b1;
            if (bvalid && bready) bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) aw_addr_q <= awaddr;
      if (w_hs) begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
      if (arvalid && arready) rdata <= rd_word;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   assign cfg.ctrl      = ctrl_q;
   assign cfg.err_clear = clear_q;

endmodule

// ==== source/prbs_next_word.sv ====
`include "prbs_chk_defs.svh"

module prbs_next_word import prbs_chk_data_pkg::*; (
   input  prbs_word_t seed,
   input  prbs_mode_e mode,
   output prbs_word_t next
);

   prbs_word_t sr;
   logic       fb;

   // fibonacci lfsr, one output bit per step
   // after a full word of steps the register holds exactly the generated bits,
   // first bit at the msb and the final state in the low bits
   always_comb begin
      sr = seed;
      fb = 1'b0;
      for (int i = 0; i < `PRBS_DATA_W; i++) begin
         case (mode)
            PRBS15:  fb = sr[14] ^ sr[13];
            PRBS31:  fb = sr[30] ^ sr[27];
            default: fb = sr[6] ^ sr[5];  // prbs7
         endcase
         sr = {sr[`PRBS_DATA_W-2:0], fb};
      end
   end

   assign next = sr;

endmodule

// ==== source/prbs_tracker.sv ====
`include "prbs_chk_defs.svh"

module prbs_tracker import prbs_chk_data_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  prbs_word_t  prbs_data,
   input  byte_idx_t   byte_en,
   input  logic        data_en,
   input  logic        header_en,
   prbs_chk_cfg_if.chk cfg,
   output logic        check_pulse,
   output logic        fail_pulse,
   output prbs_word_t  diff
);

   prbs_word_t             seed_q;
   prbs_word_t             seed_d;
   prbs_word_t             exp_word;
   prbs_word_t             data_aln;
   prbs_word_t             byte_mask;
   prbs_word_t             in_masked;
   prbs_word_t             exp_masked;
   logic [5:0]             shift;
   logic [`PRBS_CNT_W-1:0] match_q;
   logic [`PRBS_CNT_W-1:0] tol_q;
   logic                   locked_q;
   logic                   locked_d;
   logic                   lock_set;
   logic                   header_d1;
   logic                   restart;
   logic                   match;
   logic                   force_check;

   prbs_next_word u_next (
      .seed (seed_q),
      .mode (cfg.ctrl.mode),
      .next (exp_word)
   );

   assign data_aln   = cfg.ctrl.order ? ~prbs_data : prbs_data;
   assign shift      = {~byte_en, 3'b000};  // bit count above the valid bytes
   assign byte_mask  = {`PRBS_DATA_W{1'b1}} >> shift;
   assign in_masked  = data_aln & byte_mask;
   assign exp_masked = exp_word & byte_mask;
   assign match      = (in_masked == exp_masked);
   assign diff       = in_masked ^ exp_masked;

   // before lock the stream itself is the seed
   assign seed_d = (cfg.ctrl.load || !locked_q) ? (data_aln >> shift) : (exp_word >> shift);

   assign restart     = (header_en & ~header_d1) | ~cfg.ctrl.chk_en;
   assign check_pulse = cfg.ctrl.chk_en & data_en;
   assign lock_set    = ~locked_q & match & (match_q == cfg.ctrl.match_cnt);
   assign locked_d    = locked_q | lock_set;
   assign force_check = (tol_q >= cfg.ctrl.tolerance);
   assign fail_pulse  = check_pulse & ~match & (locked_d | force_check);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         header_d1 <= 1'b0;
      end else begin
         header_d1 <= header_en;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         seed_q   <= '1;
         match_q  <= '0;
         tol_q    <= '0;
         locked_q <= 1'b0;
      end else if (restart) begin
         seed_q   <= '1;
         match_q  <= '0;
         tol_q    <= '0;
         locked_q <= 1'b0;
      end else if (check_pulse) begin
         seed_q   <= seed_d;
         locked_q <= locked_d;
         if (tol_q < cfg.ctrl.tolerance) tol_q <= tol_q + 1'b1;
         if (!locked_q) begin
            if (match) begin
               if (!lock_set) match_q <= match_q + 1'b1;
            end else if (cfg.ctrl.lock_continue) begin
               match_q <= '0;  // run broken, start over
            end
         end
      end
   end

endmodule

// ==== source/prbs_err_stats.sv ====
`include "prbs_chk_defs.svh"

module prbs_err_stats import prbs_chk_data_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        check_pulse,
   input  logic        fail_pulse,
   input  prbs_word_t  diff,
   prbs_chk_cfg_if.chk cfg
);

   logic                          check_q;
   logic                          fail_q;
   logic [`PRBS_ERR_W-1:0]        err_q;
   logic [$clog2(`PRBS_DATA_W):0] bit_cnt;
   logic [`PRBS_ERR_W:0]          err_sum;

   // errored bits in this beat
   always_comb begin
      bit_cnt = '0;
      for (int i = 0; i < `PRBS_DATA_W; i++) begin
         bit_cnt = bit_cnt + diff[i];
      end
   end

   assign err_sum = {1'b0, err_q} + bit_cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         check_q <= 1'b0;
         fail_q  <= 1'b0;
      end else if (cfg.err_clear) begin
         check_q <= 1'b0;
         fail_q  <= 1'b0;
      end else begin
         if (check_pulse) check_q <= 1'b1;
         if (fail_pulse) fail_q <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_q <= '0;
      end else if (!cfg.ctrl.chk_en || cfg.err_clear || (check_pulse && !check_q)) begin
         err_q <= '0;  // fresh count with the first checked beat
      end else if (fail_pulse) begin
         err_q <= err_sum[`PRBS_ERR_W] ? '1 : err_sum[`PRBS_ERR_W-1:0];
      end
   end

   assign cfg.status = '{check: check_q, fail: fail_q, err_count: err_q};

endmodule

// ==== source/video_prbs_chk.sv ====
`include "prbs_chk_defs.svh"

module video_prbs_chk import prbs_chk_data_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`PRBS_AXI_AW-1:0] awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [31:0]             wdata,
   input  logic [3:0]              wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [`PRBS_AXI_AW-1:0] araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [31:0]             rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   input  prbs_word_t              prbs_data,
   input  byte_idx_t               byte_en,
   input  logic                    data_en,
   input  logic                    header_en
);

   logic       check_pulse;
   logic       fail_pulse;
   prbs_word_t diff;

   prbs_chk_cfg_if cfg_if ();

   prbs_chk_regs u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .cfg     (cfg_if.regs)
   );

   prbs_tracker u_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .prbs_data   (prbs_data),
      .byte_en     (byte_en),
      .data_en     (data_en),
      .header_en   (header_en),
      .cfg         (cfg_if.chk),
      .check_pulse (check_pulse),
      .fail_pulse  (fail_pulse),
      .diff        (diff)
   );

   prbs_err_stats u_stats (
      .clk         (clk),
      .rst_n       (rst_n),
      .check_pulse (check_pulse),
      .fail_pulse  (fail_pulse),
      .diff        (diff),
      .cfg         (cfg_if.chk)
   );

endmodule

// ==== verification/video_prbs_chk_assertions.sv ====
`include "prbs_chk_defs.svh"

module video_prbs_chk_assertions (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   bvalid,
   input logic                   bready,
   input logic                   rvalid,
   input logic                   rready,
   input logic                   err_clear,
   input logic                   chk_en,
   input logic                   check,
   input logic                   check_pulse,
   input logic                   restart,
   input logic [`PRBS_ERR_W-1:0] err_count
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;  // failed assertions so far

   // write and read responses hold until taken
   bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
      else begin
         fail_count++;
         $error("bvalid dropped before bready");
      end

   rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
      else begin
         fail_count++;
         $error("rvalid dropped before rready");
      end

   clear_single: assert property (@(posedge clk) disable iff (!rst_n)
      err_clear |=> !err_clear)
      else begin
         fail_count++;
         $error("err_clear held longer than one cycle");
      end

   // counter only moves up between clears
   err_count_up: assert property (@(posedge clk) disable iff (!rst_n)
      !(err_clear || !chk_en || restart || (check_pulse && !check))
      |=> err_count >= $past(err_count))
      else begin
         fail_count++;
         $error("err_count decreased without a clear");
      end

endmodule

// ==== verification/video_prbs_chk_tb.sv ====
`include "prbs_chk_defs.svh"

module video_prbs_chk_tb import prbs_chk_data_pkg::*, prbs_chk_cfg_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   typedef struct {
      prbs_mode_e mode;
      logic       order;
      logic       inv;        // stream sent inverted
      logic [3:0] match_cnt;
      logic       lock_cont;
      logic [3:0] tol;
      int         beats;
      byte_idx_t  byte_en;
      int         bad_beat;   // -1 for a clean stream
      logic       rnd;        // random error mask
      prbs_word_t mask;
      logic       hdr;        // header edge, lock state kept from the row before
      logic       exp_fail;
   } row_t;

   localparam int NROWS = 11;

   row_t rows [NROWS] = '{
      '{PRBS7,  0, 0, 4'd3, 1, 4'd2,  12, 3'd7, -1, 0, 64'h0, 0, 0},
      '{PRBS7,  0, 0, 4'd2, 1, 4'd1,  10, 3'd7, -1, 0, 64'h0, 1, 0},
      '{PRBS15, 0, 0, 4'd2, 0, 4'd1,  10, 3'd7, -1, 0, 64'h0, 0, 0},
      '{PRBS31, 0, 0, 4'd1, 1, 4'd4,  10, 3'd7, -1, 0, 64'h0, 0, 0},
      '{PRBS31, 0, 0, 4'd1, 1, 4'd8,  12, 3'd7,  8, 1, 64'h0, 0, 1},
      '{PRBS15, 1, 1, 4'd2, 0, 4'd1,  10, 3'd7, -1, 0, 64'h0, 0, 0},
      '{PRBS15, 0, 1, 4'd2, 0, 4'd0,  10, 3'd7, -1, 0, 64'h0, 0, 1},
      '{PRBS7,  0, 0, 4'd8, 0, 4'd0,   6, 3'd7,  1, 0, 64'h0000_00f0_0000_0101, 0, 1},
      '{PRBS31, 0, 0, 4'd3, 1, 4'd15, 12, 3'd7,  2, 0, 64'h1, 0, 0},
      '{PRBS15, 0, 0, 4'd1, 1, 4'd2,  10, 3'd3,  6, 0, 64'hff00_0000_0000_0000, 0, 0},
      '{PRBS15, 0, 0, 4'd1, 1, 4'd2,  10, 3'd3,  6, 0, 64'h0000_0000_0001_0200, 0, 1}
   };

   logic                    clk;
   logic                    rst_n;
   logic [`PRBS_AXI_AW-1:0] awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [31:0]             wdata;
   logic [3:0]              wstrb;
   logic                    wvalid;
   logic                    wready;
   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;
   logic [`PRBS_AXI_AW-1:0] araddr;
   logic                    arvalid;
   logic                    arready;
   logic [31:0]             rdata;
   logic [1:0]              rresp;
   logic                    rvalid;
   logic                    rready;
   prbs_word_t              prbs_data;
   byte_idx_t               byte_en;
   logic                    data_en;
   logic                    header_en;

   int seed = 32'hf50d;
   int checks;
   int errors;
   int row_idx;

   // reference state
   prbs_word_t  m_seed;
   logic [3:0]  m_cnt;
   logic [3:0]  m_tol;
   logic        m_lock;
   logic        m_check;
   logic        m_fail;
   logic [31:0] m_err;

   video_prbs_chk uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .prbs_data (prbs_data),
      .byte_en   (byte_en),
      .data_en   (data_en),
      .header_en (header_en)
   );

   bind video_prbs_chk video_prbs_chk_assertions u_assertions (
      .clk         (clk),
      .rst_n       (rst_n),
      .bvalid      (bvalid),
      .bready      (bready),
      .rvalid      (rvalid),
      .rready      (rready),
      .err_clear   (cfg_if.err_clear),
      .chk_en      (cfg_if.ctrl.chk_en),
      .check       (cfg_if.status.check),
      .check_pulse (check_pulse),
      .restart     (u_tracker.restart),
      .err_count   (cfg_if.status.err_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Mismatch %s (row %0d): got %h, expected %h", name, row_idx, got, exp);
      end
   endtask

   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic aw_hs;
      logic w_hs;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = strb;
      wvalid  = 1'b1;
      while (awvalid || wvalid) begin
         aw_hs = awvalid && awready;  // taken at the coming rising edge
         w_hs  = wvalid && wready;
         @(negedge clk);
         if (aw_hs) awvalid = 1'b0;
         if (w_hs) wvalid = 1'b0;
      end
      while (!bvalid) @(negedge clk);
      @(negedge clk);  // response waits a cycle before it is taken
      bready = 1'b1;
      check_value("bresp", bresp, 2'b00);
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready) @(negedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      @(negedge clk);  // response waits a cycle before it is taken
      data = rdata;
      check_value("rresp", rresp, 2'b00);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   // 64 steps of the two-tap lfsr, first bit at the msb
   function automatic prbs_word_t ref_next(input prbs_word_t s, input prbs_mode_e mode);
      int          n;
      int          m;
      logic [30:0] st;
      logic        b;
      prbs_word_t  out;
      case (mode)
         PRBS15: begin
            n = 15;
            m = 14;
         end
         PRBS31: begin
            n = 31;
            m = 28;
         end
         default: begin
            n = 7;
            m = 6;
         end
      endcase
      st = s[30:0];
      for (int i = 0; i < 64; i++) begin
         b = st[n-1] ^ st[m-1];
         out[63-i] = b;
         st = {st[29:0], b};
      end
      return out;
   endfunction

   function automatic logic [31:0] ctrl_word(input row_t row);
      prbs_ctrl_t c;
      c = '0;
      c.chk_en        = 1'b1;
      c.mode          = row.mode;
      c.order         = row.order;
      c.lock_continue = row.lock_cont;
      c.tolerance     = row.tol;
      c.match_cnt     = row.match_cnt;
      return {16'h0000, c};
   endfunction

   task automatic tracker_restart();
      m_seed = '1;
      m_cnt  = '0;
      m_tol  = '0;
      m_lock = 1'b0;
   endtask

   task automatic model_beat(input prbs_word_t din, input row_t row);
      prbs_word_t  aln;
      prbs_word_t  vmask;
      prbs_word_t  expw;
      prbs_word_t  d;
      int          shift;
      logic        match;
      logic        lock_set;
      logic        lk;
      logic        fail;
      logic [32:0] sum;
      shift = (7 - int'(row.byte_en)) * 8;
      aln   = row.order ? ~din : din;
      vmask = '1;
      vmask = vmask >> shift;
      expw  = ref_next(m_seed, row.mode);
      d     = (aln & vmask) ^ (expw & vmask);
      match = (d == '0);
      lock_set = !m_lock && match && (m_cnt == row.match_cnt);
      lk    = m_lock || lock_set;
      fail  = !match && (lk || (m_tol >= row.tol));
      sum   = {1'b0, m_err} + $countones(d);
      if (!m_check) m_err = '0;  // first checked beat starts a fresh count
      else if (fail) m_err = sum[32] ? '1 : sum[31:0];
      m_check = 1'b1;
      if (fail) m_fail = 1'b1;
      if (!m_lock) begin
         if (match && !lock_set) m_cnt++;
         else if (!match && row.lock_cont) m_cnt = '0;
      end
      m_seed = m_lock ? (expw >> shift) : (aln >> shift);
      m_lock = lk;
      if (m_tol < row.tol) m_tol++;
   endtask

   task automatic run_row(input int r);
      row_t        row;
      prbs_word_t  gen_seed;
      prbs_word_t  word;
      prbs_word_t  err_mask;
      logic [31:0] rd;
      int          shift;
      row      = rows[r];
      row_idx  = r;
      err_mask = row.rnd ? {$random(seed), $random(seed)} : row.mask;
      gen_seed = {$random(seed), $random(seed)} | 64'h1;
      shift    = (7 - int'(row.byte_en)) * 8;
      if (!row.hdr) begin
         axi_write(`PRBS_REG_CTRL, 32'h0, 4'hf);  // disable restarts everything
         tracker_restart();
         m_err = '0;
      end
      axi_write(`PRBS_REG_CLEAR, 32'h1, 4'hf);
      m_check = 1'b0;
      m_fail  = 1'b0;
      m_err   = '0;
      axi_write(`PRBS_REG_CTRL, ctrl_word(row), 4'hf);
      if (row.hdr) begin
         header_en = 1'b1;
         @(negedge clk);
         header_en = 1'b0;
         tracker_restart();
      end
      for (int b = 0; b < row.beats; b++) begin
         word     = ref_next(gen_seed, row.mode);
         gen_seed = word >> shift;
         if (row.inv) word = ~word;
         if (b == row.bad_beat) word = word ^ err_mask;
         prbs_data = word;
         byte_en   = row.byte_en;
         data_en   = 1'b1;
         model_beat(word, row);
         @(negedge clk);
         check_value("lock", uut.u_tracker.locked_q, m_lock);  // lock follows each beat
      end
      data_en = 1'b0;
      repeat (2) @(negedge clk);
      axi_read(`PRBS_REG_STATUS, rd);
      check_value("check", rd[0], m_check);
      check_value("fail", rd[1], m_fail);
      axi_read(`PRBS_REG_ERR, rd);
      check_value("err_count", rd, m_err);
      check_value("fail vs table", m_fail, row.exp_fail);
      axi_write(`PRBS_REG_CLEAR, 32'h1, 4'hf);
      m_check = 1'b0;
      m_fail  = 1'b0;
      m_err   = '0;
      axi_read(`PRBS_REG_STATUS, rd);
      check_value("status after clear", rd, 32'h0);
      axi_read(`PRBS_REG_ERR, rd);
      check_value("err_count after clear", rd, 32'h0);
   endtask

   initial begin
      logic [31:0] rd;
      rst_n     = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      prbs_data = '0;
      byte_en   = '0;
      data_en   = 1'b0;
      header_en = 1'b0;
      checks    = 0;
      errors    = 0;
      row_idx   = -1;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      axi_read(`PRBS_REG_STATUS, rd);
      check_value("status", rd, 32'h0);
      axi_read(`PRBS_REG_ERR, rd);
      check_value("err_count", rd, 32'h0);
      axi_write(`PRBS_REG_CTRL, 32'hffff_ffff, 4'hf);
      axi_read(`PRBS_REG_CTRL, rd);
      check_value("ctrl", rd, 32'h0000_ff7f);  // bit 7 reserved
      axi_write(`PRBS_REG_CTRL, 32'h0000_3400, 4'b0010);
      axi_read(`PRBS_REG_CTRL, rd);
      check_value("ctrl", rd, 32'h0000_347f);
      axi_read(4'h6, rd);
      check_value("unmapped", rd, 32'h0);
      axi_write(`PRBS_REG_CTRL, 32'h0, 4'hf);
      tracker_restart();
      m_check = 1'b0;
      m_fail  = 1'b0;
      m_err   = '0;
      for (int r = 0; r < NROWS; r++) begin
         run_row(r);
      end
      $display("checks: %0d, mismatches: %0d, assertion failures: %0d", checks, errors,
               uut.u_assertions.fail_count);
      if (errors == 0 && uut.u_assertions.fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      int limit;
      limit = 400;
      foreach (rows[i]) limit += rows[i].beats * 20 + 150;
      repeat (limit) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+source
source/prbs_chk_data_pkg.sv
source/prbs_chk_cfg_pkg.sv
source/prbs_chk_cfg_if.sv
source/prbs_chk_regs.sv
source/prbs_next_word.sv
source/prbs_tracker.sv
source/prbs_err_stats.sv
source/video_prbs_chk.sv
verification/video_prbs_chk_assertions.sv
verification/video_prbs_chk_tb.sv

// ==== Bender.yml ====
package:
  name: video_prbs_chk

sources:
  - include_dirs:
      - source
    files:
      - source/prbs_chk_data_pkg.sv
      - source/prbs_chk_cfg_pkg.sv
      - source/prbs_chk_cfg_if.sv
      - source/prbs_chk_regs.sv
      - source/prbs_next_word.sv
      - source/prbs_tracker.sv
      - source/prbs_err_stats.sv
      - source/video_prbs_chk.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/video_prbs_chk_assertions.sv
      - verification/video_prbs_chk_tb.sv
